// File: hdl/event_flasher.sv
`timescale 1ns/100ps

module event_flasher (
  input  logic async_clock,
  input  logic rst_i,
  input  logic event_i,   // one cycle strobe
  output logic flash_o    // stretched to FLASH_CYCLES
);

  logic [led_pkg::FLASH_CNT_W-1:0] flash_cnt;  // cycles of flash left

  // ------------------------------------------------------------
  // down counter reloaded by every event
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      flash_cnt <= '0;
    end else if (event_i) begin
      flash_cnt <= led_pkg::FLASH_LOAD;  // retrigger restarts the flash
    end else if (flash_cnt != '0) begin
      flash_cnt <= flash_cnt - 1'b1;
    end
  end

  // lit from the cycle after the event until the count runs out
  assign flash_o = (flash_cnt != '0);

  // the count only ever comes down from the load value
  a_flash_cnt_range : assert property (
    @(posedge async_clock) disable iff (rst_i)
    flash_cnt <= led_pkg::FLASH_LOAD
  ) else $error("flash counter above load value");

endmodule

// File: hdl/led_control.sv
`timescale 1ns/100ps

module led_control (
  input  logic                       async_clock,
  input  logic                       rst_i,
  input  logic                       gbt_rxready_i,
  input  logic                       gbt_rxvalid_i,
  input  logic                       mmcm_locked_i,
  input  logic                       gbt_link_ready_i,
  input  logic                       gbt_request_i,
  input  logic                       ttc_l1a_i,
  input  logic                       ttc_bc0_i,
  input  logic                       ttc_resync_i,
  input  logic                       vfat_reset_i,
  input  logic [led_pkg::LED_W-1:0]  gbt_rx_data_i,
  input  logic                       led_sync_mode_i,
  input  logic [led_pkg::INC_W-1:0]  cluster_count_i,
  output logic [led_pkg::CNT_W-1:0]  cluster_rate_o,
  output logic [led_pkg::LED_W-1:0]  led_o
);

  logic [led_pkg::LED_W-1:0]  gbt_rx_data_q;
  logic                       led_sync_mode_q;
  logic [led_pkg::INC_W-1:0]  cluster_count_q;
  logic                       link_good;
  logic [led_pkg::LAMP_W-1:0] lamp_bits;
  logic [led_pkg::BAR_W-1:0]  bar;
  logic                       fader;

  // ------------------------------------------------------------
  // input registers
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    gbt_rx_data_q   <= gbt_rx_data_i;    // raw pattern, one cycle
    cluster_count_q <= cluster_count_i;
    if (rst_i) led_sync_mode_q <= 1'b0;
    else led_sync_mode_q <= led_sync_mode_i;
  end

  // all three must hold before anything but the fader is shown
  assign link_good = gbt_rxready_i & gbt_rxvalid_i & mmcm_locked_i;

  status_lamps u_status_lamps (
    .async_clock      (async_clock),
    .rst_i            (rst_i),
    .gbt_request_i    (gbt_request_i),
    .ttc_l1a_i        (ttc_l1a_i),
    .ttc_bc0_i        (ttc_bc0_i),
    .ttc_resync_i     (ttc_resync_i),
    .vfat_reset_i     (vfat_reset_i),
    .gbt_link_ready_i (gbt_link_ready_i),
    .lamp_bits_o      (lamp_bits),
    .fader_o          (fader)
  );

  rate_meter u_rate_meter (
    .async_clock (async_clock),
    .rst_i       (rst_i),
    .increment_i (cluster_count_q),
    .rate_o      (cluster_rate_o),
    .bar_o       (bar)
  );

  led_source_mux u_led_source_mux (
    .async_clock     (async_clock),
    .rst_i           (rst_i),
    .lamp_bits_i     (lamp_bits),
    .bar_i           (bar),
    .fader_i         (fader),
    .rx_word_i       (gbt_rx_data_q),
    .sync_mode_i     (led_sync_mode_q),
    .link_good_i     (link_good),
    .cluster_count_i (cluster_count_q),
    .ttc_resync_i    (ttc_resync_i),
    .led_o           (led_o)
  );

endmodule

// File: hdl/led_pkg.sv
package led_pkg;

  // ------------------------------------------------------------
  // display geometry
  // ------------------------------------------------------------
  localparam int LED_W  = 16;  // front panel LEDs
  localparam int LAMP_W = 8;   // status lamps in the upper byte
  localparam int BAR_W  = 8;   // rate bar in the lower byte

  // ------------------------------------------------------------
  // blinkers and fader
  // ------------------------------------------------------------
  localparam int BLINK_DIV_W = 4;  // heartbeat toggles every 2**4 cycles
  localparam int FADER_W     = 8;  // triangle ramp counter
  localparam int PWM_W       = 4;  // brightness resolution of the fader

  // event flash length, and the value loaded into the flash counter
  localparam int FLASH_CYCLES = 8;
  localparam int FLASH_CNT_W  = $clog2(FLASH_CYCLES + 1);
  localparam logic [FLASH_CNT_W-1:0] FLASH_LOAD = FLASH_CNT_W'(FLASH_CYCLES);

  // ------------------------------------------------------------
  // cluster rate meter
  // ------------------------------------------------------------
  localparam int RATE_WINDOW = 64;                  // cycles per window
  localparam int WIN_W       = $clog2(RATE_WINDOW);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(RATE_WINDOW - 1);
  localparam int CNT_W       = 32;                  // sum and rate width
  localparam int INC_W       = 8;                   // clusters per bx

  // cylon scanner, steps every 2**CYLON_DIV_W cycles
  localparam int CYLON_DIV_W = 3;
  localparam int SCAN_W      = $clog2(BAR_W);
  localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(BAR_W - 1);

  // ------------------------------------------------------------
  // LED word, seen either as raw GBT bits or as the logic layout
  // ------------------------------------------------------------
  typedef struct packed {
    logic             eclk_blink;        // led 15
    logic             clk_blink;         // led 14
    logic             link_fade;         // led 13, fader while link ready
    logic             gbt_flash;         // led 12
    logic             l1a_flash;         // led 11
    logic             resync_flash;      // led 10
    logic             bc0_flash;         // led 9
    logic             vfat_reset_flash;  // led 8
    logic [BAR_W-1:0] bar;               // rate bar or cylon
  } led_logic_t;

  typedef union packed {
    logic [LED_W-1:0] raw;         // as sent over GBT in sync mode
    led_logic_t       logic_view;  // lamps over bar
  } led_word_u;

endpackage

// File: hdl/led_source_mux.sv
`timescale 1ns/100ps

module led_source_mux (
  input  logic                       async_clock,
  input  logic                       rst_i,
  input  logic [led_pkg::LAMP_W-1:0] lamp_bits_i,
  input  logic [led_pkg::BAR_W-1:0]  bar_i,
  input  logic                       fader_i,
  input  logic [led_pkg::LED_W-1:0]  rx_word_i,     // registered GBT pattern
  input  logic                       sync_mode_i,
  input  logic                       link_good_i,
  input  logic [led_pkg::INC_W-1:0]  cluster_count_i,
  input  logic                       ttc_resync_i,
  output logic [led_pkg::LED_W-1:0]  led_o
);

  logic [led_pkg::CYLON_DIV_W-1:0] scan_div;
  logic [led_pkg::SCAN_W-1:0]      scan_pos;   // lit LED of the scanner
  logic                            scan_up;    // direction of travel
  logic [led_pkg::BAR_W-1:0]       cylon;
  logic                            cylon_mode; // no cluster seen this run
  led_pkg::led_word_u              led_next;

  // ------------------------------------------------------------
  // cylon scanner, bounces between LED 0 and LED BAR_W-1
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      scan_div <= '0;
      scan_pos <= '0;
      scan_up  <= 1'b1;
    end else begin
      scan_div <= scan_div + 1'b1;
      if (scan_div == '1) begin  // one step per divider period
        if (scan_up && scan_pos == led_pkg::SCAN_LAST) begin
          scan_up  <= 1'b0;
          scan_pos <= scan_pos - 1'b1;
        end else if (!scan_up && scan_pos == '0) begin
          scan_up  <= 1'b1;
          scan_pos <= scan_pos + 1'b1;
        end else begin
          scan_pos <= scan_up ? scan_pos + 1'b1 : scan_pos - 1'b1;
        end
      end
    end
  end

  always_comb begin
    cylon           = '0;
    cylon[scan_pos] = 1'b1;
  end

  // leave cylon mode on the first cluster, a resync starts a new run
  always_ff @(posedge async_clock) begin
    if (rst_i || ttc_resync_i) cylon_mode <= 1'b1;
    else if (cluster_count_i != '0) cylon_mode <= 1'b0;
  end

  // ------------------------------------------------------------
  // source select
  // ------------------------------------------------------------
  always_comb begin
    led_next = '0;
    if (!link_good_i) begin
      led_next.raw = {led_pkg::LED_W{fader_i}};  // no link, whole panel breathes
    end else if (sync_mode_i) begin
      led_next.raw = rx_word_i;
    end else begin
      {led_next.logic_view.eclk_blink, led_next.logic_view.clk_blink,
       led_next.logic_view.link_fade, led_next.logic_view.gbt_flash,
       led_next.logic_view.l1a_flash, led_next.logic_view.resync_flash,
       led_next.logic_view.bc0_flash, led_next.logic_view.vfat_reset_flash} = lamp_bits_i;
      led_next.logic_view.bar = cylon_mode ? cylon : bar_i;
    end
  end

  always_ff @(posedge async_clock) begin
    if (rst_i) led_o <= '0;
    else led_o <= led_next.raw;
  end

  a_cylon_onehot : assert property (
    @(posedge async_clock) disable iff (rst_i)
    $onehot(cylon)
  ) else $error("cylon pattern is not one-hot");

endmodule

// File: hdl/rate_meter.sv
`timescale 1ns/100ps

module rate_meter (
  input  logic                      async_clock,
  input  logic                      rst_i,
  input  logic [led_pkg::INC_W-1:0] increment_i,  // clusters this cycle
  output logic [led_pkg::CNT_W-1:0] rate_o,       // sum over last full window
  output logic [led_pkg::BAR_W-1:0] bar_o         // log2 thermometer of rate
);

  logic [led_pkg::WIN_W-1:0] win_cnt;      // position inside the window
  logic                      win_last;     // last cycle of the window
  logic [led_pkg::CNT_W-1:0] acc;          // running sum of this window
  logic [led_pkg::CNT_W-1:0] increment_ext;
  logic [led_pkg::BAR_W-1:0] bar_next;

  // ------------------------------------------------------------
  // log bar
  // ------------------------------------------------------------
  // bit b is lit when sum >= 2**b, which is the same as
  // floor(log2 sum) >= b; anything past the top bit just
  // saturates the bar, and zero lights nothing
  function automatic logic [led_pkg::BAR_W-1:0] log_bar(
    input logic [led_pkg::CNT_W-1:0] sum
  );
    logic [led_pkg::BAR_W-1:0] bar;
    bar = '0;
    for (int b = 0; b < led_pkg::BAR_W; b++) begin
      bar[b] = ((sum >> b) != '0);
    end
    return bar;
  endfunction

  // zero extend the per cycle count to the accumulator width
  assign increment_ext = {{(led_pkg::CNT_W-led_pkg::INC_W){1'b0}}, increment_i};

  assign win_last = (win_cnt == led_pkg::WIN_LAST);

  assign bar_next = log_bar(acc);  // bar of the sum about to be latched

  // ------------------------------------------------------------
  // window counter
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;  // wraps after RATE_WINDOW cycles
    end
  end

  // ------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      acc <= '0;
    end else if (win_last) begin
      acc <= increment_ext;  // next window starts with this cycle's count
    end else begin
      acc <= acc + increment_ext;
    end
  end

  // ------------------------------------------------------------
  // rate and bar held between window ends
  // ------------------------------------------------------------
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      rate_o <= '0;
      bar_o  <= '0;
    end else if (win_last) begin
      rate_o <= acc;
      bar_o  <= bar_next;
    end
  end

  // bar lights from bit 0 upward with no gaps
  a_bar_thermo : assert property (
    @(posedge async_clock) disable iff (rst_i)
    ((bar_o + 1'b1) & bar_o) == '0
  ) else $error("rate bar is not a thermometer code");

endmodule

// File: hdl/status_lamps.sv
`timescale 1ns/100ps

module status_lamps (
  input  logic                      async_clock,
  input  logic                      rst_i,
  input  logic                      gbt_request_i,
  input  logic                      ttc_l1a_i,
  input  logic                      ttc_bc0_i,
  input  logic                      ttc_resync_i,
  input  logic                      vfat_reset_i,
  input  logic                      gbt_link_ready_i,
  output logic [led_pkg::LAMP_W-1:0] lamp_bits_o,  // logic view order, eclk on top
  output logic                      fader_o
);

  logic [led_pkg::BLINK_DIV_W-1:0] clk_div;
  logic [led_pkg::BLINK_DIV_W-1:0] eclk_div;
  logic                            clk_blink;
  logic                            eclk_blink;
  logic [led_pkg::FADER_W-1:0]     fader_cnt;
  logic [led_pkg::PWM_W-1:0]       brightness;
  logic [led_pkg::PWM_W:0]         pwm_acc;     // carry bit is the pwm output
  logic gbt_flash, l1a_flash, resync_flash, bc0_flash, vfat_reset_flash;

  // ------------------------------------------------------------
  // heartbeat blinkers
  // ------------------------------------------------------------
  // both divide by the same amount; eclk starts half a period
  // away so the two lamps visibly alternate
  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      clk_div    <= '0;
      eclk_div   <= {1'b1, {(led_pkg::BLINK_DIV_W-1){1'b0}}};
      clk_blink  <= 1'b0;
      eclk_blink <= 1'b0;
    end else begin
      clk_div  <= clk_div + 1'b1;
      eclk_div <= eclk_div + 1'b1;
      if (clk_div == '0) clk_blink <= ~clk_blink;     // toggle on wrap
      if (eclk_div == '0) eclk_blink <= ~eclk_blink;
    end
  end

  // ------------------------------------------------------------
  // pwm fader
  // ------------------------------------------------------------
  // top ramp bit picks rising or falling half of the triangle
  assign brightness = fader_cnt[led_pkg::FADER_W-1] ?
                      fader_cnt[led_pkg::FADER_W-2 -: led_pkg::PWM_W] :
                      ~fader_cnt[led_pkg::FADER_W-2 -: led_pkg::PWM_W];

  always_ff @(posedge async_clock) begin
    if (rst_i) begin
      fader_cnt <= '0;
      pwm_acc   <= '0;
    end else begin
      fader_cnt <= fader_cnt + 1'b1;
      // first order accumulator, duty cycle = brightness / 2**PWM_W
      pwm_acc <= {1'b0, pwm_acc[led_pkg::PWM_W-1:0]} + {1'b0, brightness};
    end
  end

  assign fader_o = pwm_acc[led_pkg::PWM_W];

  // ------------------------------------------------------------
  // event flashes
  // ------------------------------------------------------------
  event_flasher u_flash_gbt (
    .async_clock (async_clock), .rst_i (rst_i),
    .event_i     (gbt_request_i), .flash_o (gbt_flash)
  );
  event_flasher u_flash_l1a (
    .async_clock (async_clock), .rst_i (rst_i),
    .event_i     (ttc_l1a_i), .flash_o (l1a_flash)
  );
  event_flasher u_flash_resync (
    .async_clock (async_clock), .rst_i (rst_i),
    .event_i     (ttc_resync_i), .flash_o (resync_flash)
  );
  event_flasher u_flash_bc0 (
    .async_clock (async_clock), .rst_i (rst_i),
    .event_i     (ttc_bc0_i), .flash_o (bc0_flash)
  );
  event_flasher u_flash_vfat_reset (
    .async_clock (async_clock), .rst_i (rst_i),
    .event_i     (vfat_reset_i), .flash_o (vfat_reset_flash)
  );

  // same order as the upper byte of led_word_u
  assign lamp_bits_o = {eclk_blink, clk_blink,
                        gbt_link_ready_i & fader_o,  // link lamp breathes when ready
                        gbt_flash, l1a_flash, resync_flash,
                        bc0_flash, vfat_reset_flash};

endmodule

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run; status follows the search for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module tb_led_control -f tb.f -o sim_led_control \
  && ./obj_dir/sim_led_control | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb.f
hdl/led_pkg.sv
hdl/event_flasher.sv
hdl/status_lamps.sv
hdl/rate_meter.sv
hdl/led_source_mux.sv
hdl/led_control.sv
testbench/tb_clock_gen.sv
testbench/led_checker.sv
testbench/tb_led_control.sv

// File: testbench/led_checker.sv
`timescale 1ns/100ps

module led_checker (
  input  logic                        async_clock,
  input  logic                        rst_i,
  input  logic                        gbt_rxready_i,
  input  logic                        gbt_rxvalid_i,
  input  logic                        mmcm_locked_i,
  input  logic                        gbt_link_ready_i,
  input  logic                        gbt_request_i,
  input  logic                        ttc_l1a_i,
  input  logic                        ttc_bc0_i,
  input  logic                        ttc_resync_i,
  input  logic                        vfat_reset_i,
  input  logic [led_pkg::LED_W-1:0]   gbt_rx_data_i,
  input  logic                        led_sync_mode_i,
  input  logic [led_pkg::INC_W-1:0]   cluster_count_i,
  input  logic [led_pkg::CNT_W-1:0]   cluster_rate_i,  // dut cluster_rate_o
  input  logic [led_pkg::LED_W-1:0]   led_i,           // dut led_o
  input  int                          phase_i,         // behavior under test, 0 between
  output int                          check_cnt_o,
  output int                          error_cnt_o
);

  int                        checks = 0;
  int                        errors = 0;
  int                        win_pos;                 // model position in the window
  logic [led_pkg::CNT_W-1:0] win_sum, exp_rate;
  logic [led_pkg::INC_W-1:0] inc_q;                   // model of the input register
  logic                      win_end;                 // last rising edge closed a window
  logic [led_pkg::CNT_W-1:0] rate_prev;
  logic [led_pkg::LED_W-1:0] rx_d1, rx_d2;            // rx words one and two cycles back
  logic [led_pkg::BAR_W-1:0] scan_prev, bar_due_val;
  logic                      bar_due = 1'b0;
  logic                      seen_lo, seen_hi;
  int                        prev_phase = 0;
  int                        rx_seen, moves, flash_len;
  int                        l1a_age = -1;            // cycles since the l1a pulse

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

  // floor(log2 sum) as a thermometer, capped at BAR_W bits, nothing for zero
  function automatic logic [led_pkg::BAR_W-1:0] expected_bar(input logic [31:0] sum);
    int                        msb;
    logic [led_pkg::BAR_W-1:0] bar;
    msb = -1;
    for (int i = 0; i < 32; i++) if (sum[i]) msb = i;
    bar = '0;
    for (int i = 0; i < led_pkg::BAR_W; i++) if (i <= msb) bar[i] = 1'b1;
    return bar;
  endfunction

  task automatic record_check(input logic ok, input string msg);
    checks++;
    if (!ok) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s", $time, msg);
    end
  endtask

  // ------------------------------------------------------------
  // rate reference, windows counted from reset
  // ------------------------------------------------------------
  always @(posedge async_clock) begin
    if (rst_i) begin
      win_pos  = 0;
      win_sum  = '0;
      exp_rate = '0;
      win_end  = 1'b0;
    end else begin
      win_end = (win_pos == led_pkg::RATE_WINDOW - 1);
      if (win_end) begin
        exp_rate = win_sum;          // sum of the window just closed
        win_sum  = 32'(inc_q);       // closing cycle opens the next window
      end else begin
        win_sum = win_sum + 32'(inc_q);
      end
      win_pos = (win_pos + 1) % led_pkg::RATE_WINDOW;
    end
    inc_q = cluster_count_i;         // registered once in the dut
  end

  // ------------------------------------------------------------
  // compare on the falling edge, all values settled
  // ------------------------------------------------------------
  always @(negedge async_clock) begin
    if (phase_i != prev_phase) begin
      if (prev_phase == 1) record_check(seen_lo && seen_hi, "link down fader never changed");
      if (prev_phase == 3 || prev_phase == 6) record_check(moves > 0, "cylon never moved");
      seen_lo   = 1'b0;                 // fresh state for the next behavior
      seen_hi   = 1'b0;
      moves     = 0;
      rx_seen   = 0;
      flash_len = 0;
      l1a_age   = -1;
      scan_prev = '0;
    end
    prev_phase = phase_i;
    if (!rst_i) begin
      if (win_end) record_check(cluster_rate_i == exp_rate,
        $sformatf("cluster rate %0d, expected %0d", cluster_rate_i, exp_rate));
      else if (cluster_rate_i != rate_prev) record_check(1'b0, "rate moved inside a window");
      if (bar_due) record_check(led_i[7:0] == bar_due_val,
        $sformatf("bar %b, expected %b", led_i[7:0], bar_due_val));
      bar_due     = win_end && phase_i == 4;  // bar reaches led_o one cycle later
      bar_due_val = expected_bar(exp_rate);
    end
    rate_prev = cluster_rate_i;
    case (phase_i)
      1: begin  // whole panel shows the fader
        record_check(led_i == '0 || led_i == '1, $sformatf("link down led_o %h", led_i));
        if (led_i == '0) seen_lo = 1'b1;
        else if (led_i == '1) seen_hi = 1'b1;
      end
      2: begin
        if (rx_seen >= 2) record_check(led_i == rx_d2,
          $sformatf("sync led_o %h, expected %h", led_i, rx_d2));
        rx_d2 = rx_d1;
        rx_d1 = gbt_rx_data_i;
        rx_seen++;
      end
      3, 6: begin
        record_check($onehot(led_i[7:0]), $sformatf("cylon %b not one-hot", led_i[7:0]));
        if (scan_prev != '0 && led_i[7:0] != scan_prev) begin
          record_check(led_i[7:0] == (scan_prev << 1) || led_i[7:0] == (scan_prev >> 1),
            $sformatf("cylon jumped %b to %b", scan_prev, led_i[7:0]));
          moves++;
        end
        scan_prev = led_i[7:0];
      end
      5: begin  // l1a lamp on led 11
        if (ttc_l1a_i) l1a_age = 0;
        else if (l1a_age >= 0) l1a_age++;
        if (led_i[11]) begin
          if (flash_len == 0) record_check(l1a_age == 2,
            $sformatf("l1a flash rose %0d cycles after pulse", l1a_age));
          flash_len++;
        end else if (flash_len > 0) begin
          record_check(flash_len == led_pkg::FLASH_CYCLES,
            $sformatf("l1a flash lasted %0d cycles", flash_len));
          flash_len = 0;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,  // async_clock, 100 ns period
  output logic rst_o   // synchronous reset, active high
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held over the first four rising edges
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: testbench/tb_led_control.sv
`timescale 1ns/100ps

module tb_led_control;

  logic                      async_clock;
  logic                      rst_i;
  logic                      gbt_rxready_i, gbt_rxvalid_i, mmcm_locked_i, gbt_link_ready_i;
  logic                      gbt_request_i, ttc_l1a_i, ttc_bc0_i, ttc_resync_i, vfat_reset_i;
  logic [led_pkg::LED_W-1:0] gbt_rx_data_i;
  logic                      led_sync_mode_i;
  logic [led_pkg::INC_W-1:0] cluster_count_i;
  logic [led_pkg::CNT_W-1:0] cluster_rate_o;
  logic [led_pkg::LED_W-1:0] led_o;
  int                        phase = 0;      // behavior the checker is watching
  int                        checks, errors; // from the checker
  int                        timeouts = 0;
  int                        tests = 0;
  int                        check_mark = 0;
  int                        fail_mark = 0;
  int                        seed;
  int                        shift;          // scales the cluster density per window
  int                        n;

  tb_clock_gen u_clock_gen (.clk_o (async_clock), .rst_o (rst_i));

  led_control dut (
    .async_clock (async_clock), .rst_i (rst_i),
    .gbt_rxready_i (gbt_rxready_i), .gbt_rxvalid_i (gbt_rxvalid_i),
    .mmcm_locked_i (mmcm_locked_i), .gbt_link_ready_i (gbt_link_ready_i),
    .gbt_request_i (gbt_request_i), .ttc_l1a_i (ttc_l1a_i), .ttc_bc0_i (ttc_bc0_i),
    .ttc_resync_i (ttc_resync_i), .vfat_reset_i (vfat_reset_i),
    .gbt_rx_data_i (gbt_rx_data_i), .led_sync_mode_i (led_sync_mode_i),
    .cluster_count_i (cluster_count_i), .cluster_rate_o (cluster_rate_o), .led_o (led_o)
  );

  led_checker u_checker (
    .async_clock (async_clock), .rst_i (rst_i),
    .gbt_rxready_i (gbt_rxready_i), .gbt_rxvalid_i (gbt_rxvalid_i),
    .mmcm_locked_i (mmcm_locked_i), .gbt_link_ready_i (gbt_link_ready_i),
    .gbt_request_i (gbt_request_i), .ttc_l1a_i (ttc_l1a_i), .ttc_bc0_i (ttc_bc0_i),
    .ttc_resync_i (ttc_resync_i), .vfat_reset_i (vfat_reset_i),
    .gbt_rx_data_i (gbt_rx_data_i), .led_sync_mode_i (led_sync_mode_i),
    .cluster_count_i (cluster_count_i), .cluster_rate_i (cluster_rate_o), .led_i (led_o),
    .phase_i (phase), .check_cnt_o (checks), .error_cnt_o (errors)
  );

  // wait until the masked led bits do (match=1) or do not (match=0) equal value
  task automatic wait_for_led(input logic [15:0] mask, input logic [15:0] value,
                              input logic match, input int limit, input string what);
    int cnt;
    cnt = 0;
    @(negedge async_clock);
    while ((((led_o & mask) == value) != match) && cnt < limit) begin
      @(negedge async_clock);
      cnt++;
    end
    if (((led_o & mask) == value) != match) begin
      timeouts++;
      $display("timeout: %s did not happen within %0d cycles", what, limit);
    end
  endtask

  // close a behavior, the checker runs its exit checks on the way to phase 0
  task automatic end_test(input string name);
    @(posedge async_clock) phase <= 0;
    repeat (2) @(posedge async_clock);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name,
             checks - check_mark, errors + timeouts - fail_mark);
    check_mark = checks;
    fail_mark  = errors + timeouts;
  endtask

  initial begin
    seed             = 32'h9658;
    gbt_rxready_i    = 1'b1;
    gbt_rxvalid_i    = 1'b1;
    mmcm_locked_i    = 1'b0;  // link starts down
    gbt_link_ready_i = 1'b1;
    gbt_request_i    = 1'b0;
    ttc_l1a_i        = 1'b0;
    ttc_bc0_i        = 1'b0;
    ttc_resync_i     = 1'b0;
    vfat_reset_i     = 1'b0;
    gbt_rx_data_i    = '0;
    led_sync_mode_i  = 1'b0;
    cluster_count_i  = '0;
    n = 0;
    while (rst_i !== 1'b0 && n < 20) begin
      @(negedge async_clock);
      n++;
    end
    if (rst_i !== 1'b0) begin
      timeouts++;
      $display("timeout: reset was never released");
    end

    // ------------------------------------------------------------
    // link down, then sync mode, then cylon
    // ------------------------------------------------------------
    @(posedge async_clock) phase <= 1;
    repeat (80) @(posedge async_clock);
    end_test("link down");

    @(posedge async_clock);
    mmcm_locked_i   <= 1'b1;
    led_sync_mode_i <= 1'b1;
    repeat (3) @(posedge async_clock);
    phase <= 2;
    repeat (60) begin
      @(posedge async_clock);
      gbt_rx_data_i <= 16'($random(seed));
    end
    end_test("sync mode");

    @(posedge async_clock) led_sync_mode_i <= 1'b0;
    repeat (3) @(posedge async_clock);
    phase <= 3;
    repeat (80) @(posedge async_clock);
    end_test("cylon");

    // ------------------------------------------------------------
    // rate and bar, one cluster first to leave cylon mode
    // ------------------------------------------------------------
    @(posedge async_clock) cluster_count_i <= 8'd1;
    @(posedge async_clock) cluster_count_i <= '0;
    repeat (4) @(posedge async_clock);
    phase <= 4;
    for (int w = 0; w < 8; w++) begin
      shift = $random(seed) & 7;
      repeat (led_pkg::RATE_WINDOW) begin
        @(posedge async_clock);
        if (($random(seed) & 7) == 0) cluster_count_i <= 8'($random(seed)) >> shift;
        else cluster_count_i <= '0;
      end
    end
    @(posedge async_clock) cluster_count_i <= '0;
    end_test("rate and bar");

    // l1a flash on led 11
    @(posedge async_clock) phase <= 5;
    repeat (2) @(posedge async_clock);
    ttc_l1a_i <= 1'b1;
    @(posedge async_clock) ttc_l1a_i <= 1'b0;
    wait_for_led(16'h0800, 16'h0800, 1'b1, 10, "l1a flash rise");
    wait_for_led(16'h0800, 16'h0000, 1'b1, 20, "l1a flash fall");
    repeat (2) @(posedge async_clock);
    end_test("flash");

    // quiet windows bring the bar to zero, then resync brings the cylon back
    wait_for_led(16'h00ff, 16'h0000, 1'b1, 300, "bar clearing");
    @(posedge async_clock) ttc_resync_i <= 1'b1;
    @(posedge async_clock) ttc_resync_i <= 1'b0;
    wait_for_led(16'h00ff, 16'h0000, 1'b0, 10, "cylon after resync");
    @(posedge async_clock) phase <= 6;
    repeat (40) @(posedge async_clock);
    end_test("resync");

    $display("summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
             tests, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
